//--- src/wb_bus_pkg.sv
`default_nettype none

package wb_bus_pkg;

  // ####################################################################
  // wishbone pipelined bus widths
  // ####################################################################

  // byte address, the low two bits select a byte within a word.
  localparam int ADDR_WIDTH = 32;

  localparam int DATA_WIDTH = 32;  // one processor word.

  localparam int SEL_WIDTH = DATA_WIDTH / 8;  // one strobe per byte.

endpackage

`default_nettype wire

//--- src/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

  // ####################################################################
  // memory size, slave timing and bus master identifiers
  // ####################################################################

  localparam int RAM_WORDS_DEFAULT = 256;  // depth in 32-bit words.

  localparam int WAIT_STATES_DEFAULT = 1;  // extra cycles before ack.

  // arbiter port order, master 0 fetches instructions.
  typedef enum logic {
    MASTER_IMEM = 1'b0,
    MASTER_DMEM = 1'b1
  } master_id_t;

endpackage

`default_nettype wire

//--- src/wb_master_port.sv
`timescale 1ns/1ps
`default_nettype none

module wb_master_port
  import wb_bus_pkg::*;
(
  input  wire                   clock,
  input  wire                   reset,
  // processor request side
  input  wire                   valid_i,
  input  wire  [ADDR_WIDTH-1:0] addr_i,
  input  wire  [DATA_WIDTH-1:0] wdata_i,
  input  wire  [SEL_WIDTH-1:0]  wstrb_i,
  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic                  ready_o,
  // wishbone master side
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output logic [ADDR_WIDTH-1:0] wb_addr_o,
  output logic [DATA_WIDTH-1:0] wb_dat_o,
  output logic [SEL_WIDTH-1:0]  wb_sel_o,
  input  wire  [DATA_WIDTH-1:0] wb_dat_i,
  input  wire                   wb_ack_i,
  input  wire                   wb_stall_i
);

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    LOAD  = 2'd1,
    STORE = 2'd2
  } state_t;

  state_t                state;
  state_t                state_reg;

  logic                  cyc;
  logic                  cyc_reg;
  logic                  we;
  logic                  we_reg;
  logic [ADDR_WIDTH-1:0] addr;
  logic [ADDR_WIDTH-1:0] addr_reg;
  logic [DATA_WIDTH-1:0] dat;
  logic [DATA_WIDTH-1:0] dat_reg;
  logic [SEL_WIDTH-1:0]  sel;
  logic [SEL_WIDTH-1:0]  sel_reg;

  logic [DATA_WIDTH-1:0] rdata;
  logic [DATA_WIDTH-1:0] rdata_reg;
  logic                  ready;
  logic                  ready_reg;

  // ####################################################################
  // next state and next bus request
  // ####################################################################

  always_comb begin
    state = state_reg;
    cyc   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    dat   = '0;
    sel   = '0;
    rdata = '0;
    ready = 1'b0;
    case (state_reg)
      IDLE: begin
        if (valid_i) begin
          cyc  = 1'b1;
          addr = {addr_i[ADDR_WIDTH-1:2], 2'b00};  // word aligned.
          if (wstrb_i == '0) begin
            state = LOAD;
            sel   = '1;  // loads read the whole word.
          end else begin
            state = STORE;
            we    = 1'b1;
            dat   = wdata_i;
            sel   = wstrb_i;
          end
        end
      end
      LOAD: begin
        if (wb_ack_i) begin
          state = IDLE;
          rdata = wb_dat_i;
          ready = 1'b1;
        end else if (wb_stall_i) begin
          cyc  = cyc_reg;  // request unchanged under stall.
          addr = addr_reg;
          sel  = sel_reg;
        end
      end
      STORE: begin
        if (wb_ack_i) begin
          state = IDLE;
          ready = 1'b1;
        end else if (wb_stall_i) begin
          cyc  = cyc_reg;
          we   = we_reg;
          addr = addr_reg;
          dat  = dat_reg;
          sel  = sel_reg;
        end
      end
      default: begin
        state = IDLE;
      end
    endcase
  end

  // ####################################################################
  // registers
  // ####################################################################

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_reg <= IDLE;
      cyc_reg   <= 1'b0;
      ready_reg <= 1'b0;
    end else begin
      state_reg <= state;
      cyc_reg   <= cyc;
      ready_reg <= ready;
    end
  end

  always_ff @(posedge clock) begin
    we_reg    <= we;
    addr_reg  <= addr;
    dat_reg   <= dat;
    sel_reg   <= sel;
    rdata_reg <= rdata;
  end

  assign wb_cyc_o  = cyc_reg;
  assign wb_stb_o  = cyc_reg;  // single beat, stb follows cyc.
  assign wb_we_o   = we_reg;
  assign wb_addr_o = addr_reg;
  assign wb_dat_o  = dat_reg;
  assign wb_sel_o  = sel_reg;

  assign rdata_o = rdata_reg;
  assign ready_o = ready_reg;

endmodule

`default_nettype wire

//--- src/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter
  import wb_bus_pkg::*, mem_map_pkg::*;
(
  input  wire                   clock,
  input  wire                   reset,
  // master 0
  input  wire                   m0_cyc_i,
  input  wire                   m0_stb_i,
  input  wire                   m0_we_i,
  input  wire  [ADDR_WIDTH-1:0] m0_addr_i,
  input  wire  [DATA_WIDTH-1:0] m0_dat_i,
  input  wire  [SEL_WIDTH-1:0]  m0_sel_i,
  output logic [DATA_WIDTH-1:0] m0_dat_o,
  output logic                  m0_ack_o,
  output logic                  m0_stall_o,
  // master 1
  input  wire                   m1_cyc_i,
  input  wire                   m1_stb_i,
  input  wire                   m1_we_i,
  input  wire  [ADDR_WIDTH-1:0] m1_addr_i,
  input  wire  [DATA_WIDTH-1:0] m1_dat_i,
  input  wire  [SEL_WIDTH-1:0]  m1_sel_i,
  output logic [DATA_WIDTH-1:0] m1_dat_o,
  output logic                  m1_ack_o,
  output logic                  m1_stall_o,
  // shared slave
  output logic                  s_cyc_o,
  output logic                  s_stb_o,
  output logic                  s_we_o,
  output logic [ADDR_WIDTH-1:0] s_addr_o,
  output logic [DATA_WIDTH-1:0] s_dat_o,
  output logic [SEL_WIDTH-1:0]  s_sel_o,
  input  wire  [DATA_WIDTH-1:0] s_dat_i,
  input  wire                   s_ack_i,
  input  wire                   s_stall_i
);

  logic       m0_req;
  logic       m1_req;
  logic       grant;
  master_id_t winner;
  logic       accept;
  logic       m0_owns;
  logic       m1_owns;

  logic       owner_valid_reg;
  master_id_t owner_reg;
  master_id_t last_reg;

  assign m0_req = m0_cyc_i & m0_stb_i;
  assign m1_req = m1_cyc_i & m1_stb_i;

  // no new grant while a cycle is outstanding.
  always_comb begin
    grant  = 1'b0;
    winner = last_reg;
    if (!owner_valid_reg) begin
      if (m0_req && m1_req) begin
        grant  = 1'b1;
        winner = (last_reg == MASTER_IMEM) ? MASTER_DMEM : MASTER_IMEM;
      end else if (m0_req) begin
        grant  = 1'b1;
        winner = MASTER_IMEM;
      end else if (m1_req) begin
        grant  = 1'b1;
        winner = MASTER_DMEM;
      end
    end
  end

  always_comb begin
    if (winner == MASTER_IMEM) begin
      s_we_o   = m0_we_i;
      s_addr_o = m0_addr_i;
      s_dat_o  = m0_dat_i;
      s_sel_o  = m0_sel_i;
    end else begin
      s_we_o   = m1_we_i;
      s_addr_o = m1_addr_i;
      s_dat_o  = m1_dat_i;
      s_sel_o  = m1_sel_i;
    end
  end

  assign s_cyc_o = owner_valid_reg | grant;  // held until the ack.
  assign s_stb_o = grant;
  assign accept  = grant & ~s_stall_i;

  // losers and late requesters wait.
  assign m0_stall_o = owner_valid_reg | s_stall_i | (grant & (winner != MASTER_IMEM));
  assign m1_stall_o = owner_valid_reg | s_stall_i | (grant & (winner != MASTER_DMEM));

  assign m0_owns = owner_valid_reg & (owner_reg == MASTER_IMEM);
  assign m1_owns = owner_valid_reg & (owner_reg == MASTER_DMEM);

  assign m0_ack_o = s_ack_i & m0_owns;
  assign m1_ack_o = s_ack_i & m1_owns;
  assign m0_dat_o = m0_owns ? s_dat_i : '0;
  assign m1_dat_o = m1_owns ? s_dat_i : '0;

  always_ff @(posedge clock) begin
    if (!reset) begin
      owner_valid_reg <= 1'b0;
      owner_reg       <= MASTER_IMEM;
      last_reg        <= MASTER_DMEM;  // instruction port wins the first tie.
    end else if (accept) begin
      owner_valid_reg <= 1'b1;
      owner_reg       <= winner;
      last_reg        <= winner;
    end else if (s_ack_i && owner_valid_reg) begin
      owner_valid_reg <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/wb_ram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module wb_ram_slave
  import wb_bus_pkg::*, mem_map_pkg::*;
#(
  parameter int RAM_WORDS   = RAM_WORDS_DEFAULT,
  parameter int WAIT_STATES = WAIT_STATES_DEFAULT
)
(
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   cyc_i,
  input  wire                   stb_i,
  input  wire                   we_i,
  input  wire  [ADDR_WIDTH-1:0] addr_i,
  input  wire  [DATA_WIDTH-1:0] dat_i,
  input  wire  [SEL_WIDTH-1:0]  sel_i,
  output logic [DATA_WIDTH-1:0] dat_o,
  output logic                  ack_o,
  output logic                  stall_o
);

  localparam int IDX_WIDTH = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam int CNT_WIDTH = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;

  logic [DATA_WIDTH-1:0] mem [RAM_WORDS];
  logic [ADDR_WIDTH-1:0] word_addr;
  logic [IDX_WIDTH-1:0]  idx;
  logic                  accept;

  logic                  busy_reg;
  logic                  ack_reg;
  logic [CNT_WIDTH-1:0]  count_reg;
  logic [DATA_WIDTH-1:0] rdata_reg;

  assign word_addr = {2'b00, addr_i[ADDR_WIDTH-1:2]};
  assign idx       = IDX_WIDTH'(word_addr % ADDR_WIDTH'(RAM_WORDS));  // wraps.
  assign accept    = cyc_i & stb_i & ~stall_o;

  // ####################################################################
  // storage
  // ####################################################################

  always_ff @(posedge clock) begin
    if (accept) begin
      rdata_reg <= mem[idx];  // word as it was at acceptance.
      if (we_i) begin
        for (int b = 0; b < SEL_WIDTH; b++) begin
          if (sel_i[b]) begin
            mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end
    end
  end

  // ####################################################################
  // ack delay
  // ####################################################################

  always_ff @(posedge clock) begin
    if (!reset) begin
      busy_reg  <= 1'b0;
      ack_reg   <= 1'b0;
      count_reg <= '0;
    end else begin
      ack_reg <= 1'b0;
      if (accept) begin
        if (WAIT_STATES == 0) begin
          ack_reg <= 1'b1;
        end else begin
          busy_reg  <= 1'b1;
          count_reg <= CNT_WIDTH'(WAIT_STATES - 1);
        end
      end else if (busy_reg) begin
        if (count_reg == '0) begin
          busy_reg <= 1'b0;
          ack_reg  <= 1'b1;
        end else begin
          count_reg <= count_reg - 1'b1;
        end
      end
    end
  end

  assign stall_o = busy_reg | ack_reg;  // one access at a time.
  assign ack_o   = ack_reg;
  assign dat_o   = rdata_reg;

endmodule

`default_nettype wire

//--- src/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top
  import wb_bus_pkg::*, mem_map_pkg::*;
#(
  parameter int RAM_WORDS   = RAM_WORDS_DEFAULT,
  parameter int WAIT_STATES = WAIT_STATES_DEFAULT
)
(
  input  wire                   clock,
  input  wire                   reset,
  // instruction fetch
  input  wire                   imem_valid_i,
  input  wire  [ADDR_WIDTH-1:0] imem_addr_i,
  input  wire  [DATA_WIDTH-1:0] imem_wdata_i,
  input  wire  [SEL_WIDTH-1:0]  imem_wstrb_i,
  output logic [DATA_WIDTH-1:0] imem_rdata_o,
  output logic                  imem_ready_o,
  // data load/store
  input  wire                   dmem_valid_i,
  input  wire  [ADDR_WIDTH-1:0] dmem_addr_i,
  input  wire  [DATA_WIDTH-1:0] dmem_wdata_i,
  input  wire  [SEL_WIDTH-1:0]  dmem_wstrb_i,
  output logic [DATA_WIDTH-1:0] dmem_rdata_o,
  output logic                  dmem_ready_o
);

  logic                  imem_cyc;
  logic                  imem_stb;
  logic                  imem_we;
  logic [ADDR_WIDTH-1:0] imem_addr;
  logic [DATA_WIDTH-1:0] imem_wdat;
  logic [SEL_WIDTH-1:0]  imem_sel;
  logic [DATA_WIDTH-1:0] imem_rdat;
  logic                  imem_ack;
  logic                  imem_stall;

  logic                  dmem_cyc;
  logic                  dmem_stb;
  logic                  dmem_we;
  logic [ADDR_WIDTH-1:0] dmem_addr;
  logic [DATA_WIDTH-1:0] dmem_wdat;
  logic [SEL_WIDTH-1:0]  dmem_sel;
  logic [DATA_WIDTH-1:0] dmem_rdat;
  logic                  dmem_ack;
  logic                  dmem_stall;

  logic                  ram_cyc;
  logic                  ram_stb;
  logic                  ram_we;
  logic [ADDR_WIDTH-1:0] ram_addr;
  logic [DATA_WIDTH-1:0] ram_wdat;
  logic [SEL_WIDTH-1:0]  ram_sel;
  logic [DATA_WIDTH-1:0] ram_rdat;
  logic                  ram_ack;
  logic                  ram_stall;

  wb_master_port i_imem_port (
    .clock      (clock),
    .reset      (reset),
    .valid_i    (imem_valid_i),
    .addr_i     (imem_addr_i),
    .wdata_i    (imem_wdata_i),
    .wstrb_i    (imem_wstrb_i),
    .rdata_o    (imem_rdata_o),
    .ready_o    (imem_ready_o),
    .wb_cyc_o   (imem_cyc),
    .wb_stb_o   (imem_stb),
    .wb_we_o    (imem_we),
    .wb_addr_o  (imem_addr),
    .wb_dat_o   (imem_wdat),
    .wb_sel_o   (imem_sel),
    .wb_dat_i   (imem_rdat),
    .wb_ack_i   (imem_ack),
    .wb_stall_i (imem_stall)
  );

  wb_master_port i_dmem_port (
    .clock      (clock),
    .reset      (reset),
    .valid_i    (dmem_valid_i),
    .addr_i     (dmem_addr_i),
    .wdata_i    (dmem_wdata_i),
    .wstrb_i    (dmem_wstrb_i),
    .rdata_o    (dmem_rdata_o),
    .ready_o    (dmem_ready_o),
    .wb_cyc_o   (dmem_cyc),
    .wb_stb_o   (dmem_stb),
    .wb_we_o    (dmem_we),
    .wb_addr_o  (dmem_addr),
    .wb_dat_o   (dmem_wdat),
    .wb_sel_o   (dmem_sel),
    .wb_dat_i   (dmem_rdat),
    .wb_ack_i   (dmem_ack),
    .wb_stall_i (dmem_stall)
  );

  // master 0 is MASTER_IMEM, master 1 is MASTER_DMEM.
  wb_arbiter i_arbiter (
    .clock      (clock),
    .reset      (reset),
    .m0_cyc_i   (imem_cyc),
    .m0_stb_i   (imem_stb),
    .m0_we_i    (imem_we),
    .m0_addr_i  (imem_addr),
    .m0_dat_i   (imem_wdat),
    .m0_sel_i   (imem_sel),
    .m0_dat_o   (imem_rdat),
    .m0_ack_o   (imem_ack),
    .m0_stall_o (imem_stall),
    .m1_cyc_i   (dmem_cyc),
    .m1_stb_i   (dmem_stb),
    .m1_we_i    (dmem_we),
    .m1_addr_i  (dmem_addr),
    .m1_dat_i   (dmem_wdat),
    .m1_sel_i   (dmem_sel),
    .m1_dat_o   (dmem_rdat),
    .m1_ack_o   (dmem_ack),
    .m1_stall_o (dmem_stall),
    .s_cyc_o    (ram_cyc),
    .s_stb_o    (ram_stb),
    .s_we_o     (ram_we),
    .s_addr_o   (ram_addr),
    .s_dat_o    (ram_wdat),
    .s_sel_o    (ram_sel),
    .s_dat_i    (ram_rdat),
    .s_ack_i    (ram_ack),
    .s_stall_i  (ram_stall)
  );

  wb_ram_slave #(
    .RAM_WORDS   (RAM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) i_ram (
    .clock   (clock),
    .reset   (reset),
    .cyc_i   (ram_cyc),
    .stb_i   (ram_stb),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .dat_i   (ram_wdat),
    .sel_i   (ram_sel),
    .dat_o   (ram_rdat),
    .ack_o   (ram_ack),
    .stall_o (ram_stall)
  );

endmodule

`default_nettype wire

//--- verification/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem
  import wb_bus_pkg::*, mem_map_pkg::*;
();

  localparam int RAM_WORDS      = RAM_WORDS_DEFAULT;
  localparam int WAIT_STATES    = WAIT_STATES_DEFAULT;
  localparam int RANDOM_OPS     = 150;  // per port.
  localparam int DIRECTED_OPS   = 18;
  localparam int TOTAL_OPS      = RAM_WORDS + DIRECTED_OPS + 2 * RANDOM_OPS;
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * 2 * (WAIT_STATES + 4) + 100;

  logic                  clock = 1'b0;
  logic                  reset;
  logic                  imem_valid;
  logic [ADDR_WIDTH-1:0] imem_addr;
  logic [DATA_WIDTH-1:0] imem_wdata;
  logic [SEL_WIDTH-1:0]  imem_wstrb;
  logic [DATA_WIDTH-1:0] imem_rdata;
  logic                  imem_ready;
  logic                  dmem_valid;
  logic [ADDR_WIDTH-1:0] dmem_addr;
  logic [DATA_WIDTH-1:0] dmem_wdata;
  logic [SEL_WIDTH-1:0]  dmem_wstrb;
  logic [DATA_WIDTH-1:0] dmem_rdata;
  logic                  dmem_ready;

  logic [DATA_WIDTH-1:0] model_mem [RAM_WORDS];  // expected memory contents.
  logic [DATA_WIDTH-1:0] last_rdata [2];
  int                    issue_count [2];
  int                    ready_count [2];
  int                    cycle_count = 0;
  integer                seed;

  logic [ADDR_WIDTH-1:0] rnd_addr [2][RANDOM_OPS];
  logic [DATA_WIDTH-1:0] rnd_data [2][RANDOM_OPS];
  logic [SEL_WIDTH-1:0]  rnd_strb [2][RANDOM_OPS];
  int                    rnd_gap  [2][RANDOM_OPS];

  mem_subsystem_top i_dut (
    .clock        (clock),
    .reset        (reset),
    .imem_valid_i (imem_valid),
    .imem_addr_i  (imem_addr),
    .imem_wdata_i (imem_wdata),
    .imem_wstrb_i (imem_wstrb),
    .imem_rdata_o (imem_rdata),
    .imem_ready_o (imem_ready),
    .dmem_valid_i (dmem_valid),
    .dmem_addr_i  (dmem_addr),
    .dmem_wdata_i (dmem_wdata),
    .dmem_wstrb_i (dmem_wstrb),
    .dmem_rdata_o (dmem_rdata),
    .dmem_ready_o (dmem_ready)
  );

  always #5 clock = ~clock;

  // ####################################################################
  // model helpers and checks
  // ####################################################################

  function automatic int word_index(input logic [ADDR_WIDTH-1:0] addr);
    return int'((addr >> 2) % RAM_WORDS);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] word,
      input logic [DATA_WIDTH-1:0] data, input logic [SEL_WIDTH-1:0] strb);
    logic [DATA_WIDTH-1:0] merged;
    merged = word;
    for (int b = 0; b < SEL_WIDTH; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = data[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // initial contents, a function of the byte address.
  function automatic logic [DATA_WIDTH-1:0] fill_word(input int i);
    logic [ADDR_WIDTH-1:0] a;
    a = ADDR_WIDTH'(i) << 2;
    return {~a[15:0], a[15:0]} ^ 32'h1357_9bdf;
  endfunction

  function automatic string port_name(input int port);
    return (port == 0) ? "instruction port" : "data port";
  endfunction

  function automatic logic ready_of(input int port);
    return (port == 0) ? imem_ready : dmem_ready;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] rdata_of(input int port);
    return (port == 0) ? imem_rdata : dmem_rdata;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] actual,
      input logic [DATA_WIDTH-1:0] expected);
    if (actual !== expected) begin
      stop_with_error($sformatf("Fail at %0d ns: %s, got %h, expected %h",
                                $time, what, actual, expected));
    end
  endtask

  // one request, then wait for its ready and settle it against the model.
  task automatic issue(input int port, input logic [ADDR_WIDTH-1:0] addr,
      input logic [DATA_WIDTH-1:0] wdata, input logic [SEL_WIDTH-1:0] wstrb);
    int idx;
    @(posedge clock);
    if (port == 0) begin
      imem_valid <= 1'b1;
      imem_addr  <= addr;
      imem_wdata <= wdata;
      imem_wstrb <= wstrb;
    end else begin
      dmem_valid <= 1'b1;
      dmem_addr  <= addr;
      dmem_wdata <= wdata;
      dmem_wstrb <= wstrb;
    end
    issue_count[port]++;
    @(posedge clock);
    if (port == 0) begin
      imem_valid <= 1'b0;
    end else begin
      dmem_valid <= 1'b0;
    end
    @(negedge clock);
    while (!ready_of(port)) begin
      @(negedge clock);
    end
    idx = word_index(addr);
    if (wstrb == '0) begin
      check_value($sformatf("%s load at %h", port_name(port), addr),
                  rdata_of(port), model_mem[idx]);
      last_rdata[port] = rdata_of(port);
    end else begin
      model_mem[idx] = merge_bytes(model_mem[idx], wdata, wstrb);
    end
  endtask

  task automatic run_random(input int port);
    for (int n = 0; n < RANDOM_OPS; n++) begin
      repeat (rnd_gap[port][n]) @(posedge clock);
      issue(port, rnd_addr[port][n], rnd_data[port][n], rnd_strb[port][n]);
    end
  endtask

  task automatic note_ready(input int port);
    if (ready_count[port] >= issue_count[port]) begin
      stop_with_error($sformatf("Error: %s gave a ready at %0d ns with no request pending",
                                port_name(port), $time));
    end else begin
      ready_count[port]++;
    end
  endtask

  // ####################################################################
  // monitors
  // ####################################################################

  always @(negedge clock) begin
    if (imem_ready) note_ready(0);
    if (dmem_ready) note_ready(1);
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_error($sformatf("Error: the run timed out after %0d cycles", cycle_count));
    end
  end

  // ####################################################################
  // test sequence
  // ####################################################################

  initial begin
    integer mode;
    reset      <= 1'b0;
    imem_valid <= 1'b0;
    imem_addr  <= '0;
    imem_wdata <= '0;
    imem_wstrb <= '0;
    dmem_valid <= 1'b0;
    dmem_addr  <= '0;
    dmem_wdata <= '0;
    dmem_wstrb <= '0;
    issue_count = '{0, 0};
    ready_count = '{0, 0};
    seed = 32'hfbcf_8099;
    for (int p = 0; p < 2; p++) begin
      for (int n = 0; n < RANDOM_OPS; n++) begin
        rnd_addr[p][n] = ADDR_WIDTH'($unsigned($random(seed)) % (4 * RAM_WORDS));
        rnd_data[p][n] = $random(seed);
        mode = $random(seed);
        rnd_strb[p][n] = mode[0] ? SEL_WIDTH'($random(seed)) : '0;  // zero is a load.
        rnd_gap[p][n] = $unsigned($random(seed)) % 4;
      end
    end

    repeat (3) @(posedge clock);
    reset <= 1'b1;
    repeat (2) @(negedge clock);
    check_value("instruction ready after reset", DATA_WIDTH'(imem_ready), '0);
    check_value("data ready after reset", DATA_WIDTH'(dmem_ready), '0);

    for (int i = 0; i < RAM_WORDS; i++) begin
      issue(1, ADDR_WIDTH'(4 * i), fill_word(i), 4'hf);
    end

    issue(1, 32'h0000_0040, 32'hcafe_f00d, 4'hf);
    issue(1, 32'h0000_0040, '0, '0);
    check_value("load after full store", last_rdata[1], 32'hcafe_f00d);
    issue(1, 32'h0000_0043, '0, '0);  // unaligned, whole word comes back.
    check_value("unaligned load", last_rdata[1], 32'hcafe_f00d);

    issue(1, 32'h0000_0048, 32'hdead_beef, 4'b0001);
    issue(1, 32'h0000_0048, 32'h1234_5678, 4'b0110);
    issue(1, 32'h0000_0049, 32'h9abc_def0, 4'b1000);
    issue(1, 32'h0000_0048, 32'h0000_7700, 4'b0010);
    issue(1, 32'h0000_0048, '0, '0);
    check_value("load after byte stores", last_rdata[1], 32'h9a34_77ef);

    issue(1, 32'h0000_03f0, 32'h0bad_c0de, 4'hf);
    issue(0, 32'h0000_03f0, '0, '0);
    check_value("instruction fetch of data store", last_rdata[0], 32'h0bad_c0de);

    // both ports raise valid on the same edge.
    for (int r = 0; r < 4; r++) begin
      mode = $random(seed);
      fork
        issue(0, ADDR_WIDTH'(32'h100 + 8 * r), '0, '0);
        issue(1, ADDR_WIDTH'(32'h100 + 12 * r), mode, 4'hf);
      join
    end

    fork
      run_random(0);
      run_random(1);
    join

    repeat (4) @(negedge clock);
    check_value("instruction ready count", DATA_WIDTH'(ready_count[0]),
                DATA_WIDTH'(issue_count[0]));
    check_value("data ready count", DATA_WIDTH'(ready_count[1]),
                DATA_WIDTH'(issue_count[1]));
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
src/wb_bus_pkg.sv
src/mem_map_pkg.sv
src/wb_master_port.sv
src/wb_arbiter.sv
src/wb_ram_slave.sv
src/mem_subsystem_top.sv
verification/tb_mem_subsystem.sv

//--- Makefile
# Verilator flow for the memory subsystem.

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module mem_subsystem_top

obj_dir/Vtb_mem_subsystem: project.f src/*.sv verification/*.sv
	verilator --binary --timing -j 0 -f project.f --top-module tb_mem_subsystem

# the run passes only if the log holds the pass line.
sim: obj_dir/Vtb_mem_subsystem
	./obj_dir/Vtb_mem_subsystem | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
